// File: build.f
hw/soc_bus_pkg.sv
hw/periph_pkg.sv
hw/uart_tx.sv
hw/spi_ctrl.sv
hw/periph_decode.sv
hw/periph_execute.sv
hw/periph_result.sv
hw/periph_top.sv
testbench/tb_periph_top.sv

// File: Makefile
TOP = tb_periph_top

all: sim

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -Mdir obj_dir

sim: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --top-module periph_top -f build.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build sim lint clean

// File: testbench/tb_periph_top.sv
// Testbench for the peripheral block. It plays the core on the data bus and models the SPI slave.
// Concurrent assertions compare rdata, the pins, the UART frames and the SPI lines.
module tb_periph_top;

    localparam int poll_limit = 1000;

    logic                  clk;
    logic                  rst_reg_n;
    soc_bus_pkg::bus_req_t bus_req;
    soc_bus_pkg::word_t    rdata;
    soc_bus_pkg::byte_t    ui_in;
    soc_bus_pkg::byte_t    uo_out;
    soc_bus_pkg::byte_t    ui_drive;            // GPIO input pattern with MISO on bit 2
    soc_bus_pkg::byte_t    slv_byte;            // SPI slave reply
    soc_bus_pkg::byte_t    mst_byte;            // Byte expected on MOSI
    logic [2:0]            bit_ptr  = 3'd7;
    logic                  sck_prev = 1'b0;
    logic                  rd_chk;
    logic                  pin_chk;
    logic                  bit_chk;
    logic                  spi_chk;
    logic                  bit_exp;
    soc_bus_pkg::word_t    rd_exp;
    soc_bus_pkg::byte_t    pin_mask;
    soc_bus_pkg::byte_t    pin_exp;
    int                    bit_pos;

    periph_top dut_i (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .bus_req   (bus_req),
        .rdata     (rdata),
        .ui_in     (ui_in),
        .uo_out    (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // SPI slave steps to its next bit after each falling sck
    always @(negedge clk) begin
        if (uo_out[4])                   bit_ptr <= 3'd7;
        else if (sck_prev && !uo_out[5]) bit_ptr <= bit_ptr - 3'd1;
        sck_prev <= uo_out[5];
    end

    assign ui_in = {ui_drive[7:3], slv_byte[bit_ptr], ui_drive[1:0]};

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    assert property (@(posedge clk) disable iff (!rst_reg_n) rd_chk |-> rdata == rd_exp)
        else begin
            $display("MISMATCH at %0t: rdata %h, expected %h", $time, rdata, rd_exp);
            abort_run();
        end
    assert property (@(posedge clk) disable iff (!rst_reg_n)
        pin_chk |-> (uo_out & pin_mask) == pin_exp)
        else begin
            $display("MISMATCH at %0t: uo_out %h under mask %h, expected %h",
                     $time, uo_out, pin_mask, pin_exp);
            abort_run();
        end
    // UART bit centres
    assert property (@(posedge clk) disable iff (!rst_reg_n) bit_chk |-> uo_out[bit_pos] == bit_exp)
        else begin
            $display("MISMATCH at %0t: uo_out[%0d] is %b, expected %b",
                     $time, bit_pos, uo_out[bit_pos], bit_exp);
            abort_run();
        end
    assert property (@(posedge clk) disable iff (!rst_reg_n)
        spi_chk && !uo_out[4] && $rose(uo_out[5]) |-> uo_out[3] == mst_byte[bit_ptr])
        else begin
            $display("MISMATCH at %0t: MOSI bit %0d wrong", $time, bit_ptr);
            abort_run();
        end
    assert property (@(posedge clk) disable iff (!rst_reg_n) spi_chk && !uo_out[4] |-> uo_out[2])
        else begin
            $display("MISMATCH at %0t: SPI dc low during a data byte", $time);
            abort_run();
        end

    function automatic soc_bus_pkg::addr_t reg_addr(input soc_bus_pkg::reg_sel_t sel);
        return soc_bus_pkg::periph_base | (soc_bus_pkg::addr_t'(sel) << 2);
    endfunction

    task automatic bus_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::word_t data);
        @(negedge clk);
        bus_req.addr  = addr;
        bus_req.wdata = data;
        bus_req.write = 1'b1;
        @(negedge clk);
        bus_req.write = 1'b0;
    endtask

    // Captures rdata at the end of its strobe cycle and can check it against exp
    task automatic bus_read(input soc_bus_pkg::addr_t addr, input logic check,
                            input soc_bus_pkg::word_t exp, output soc_bus_pkg::word_t got);
        @(negedge clk);
        bus_req.addr = addr;
        bus_req.read = 1'b1;
        rd_exp       = exp;
        rd_chk       = check;
        @(negedge clk);
        got          = rdata;
        bus_req.read = 1'b0;
        rd_chk       = 1'b0;
    endtask

    task automatic check_pins(input soc_bus_pkg::byte_t mask, input soc_bus_pkg::byte_t exp);
        @(negedge clk);
        pin_mask = mask;
        pin_exp  = exp;
        pin_chk  = 1'b1;
        @(negedge clk);
        pin_chk = 1'b0;
    endtask

    task automatic wait_idle(input soc_bus_pkg::reg_sel_t stat_reg, input string what);
        soc_bus_pkg::word_t got;
        int                 n;
        n = 0;
        do begin
            bus_read(reg_addr(stat_reg), 1'b0, '0, got);
            n++;
        end while (got[0] && n < poll_limit);
        if (got[0]) begin
            $display("timeout: %s still busy after %0d polls", what, n);
            abort_run();
        end
    endtask

    task automatic sample_frame(input int pin, input int cpb, input soc_bus_pkg::byte_t data);
        int n;
        n = 0;
        while (uo_out[pin] && n < poll_limit) begin
            @(negedge clk);
            n++;
        end
        if (uo_out[pin]) begin
            $display("timeout: no UART start bit on uo_out[%0d]", pin);
            abort_run();
        end
        repeat (cpb / 2 - 1) @(negedge clk);
        for (int k = 0; k < 10; k++) begin
            bit_pos = pin;
            bit_exp = (k == 0) ? 1'b0 : (k == 9) ? 1'b1 : data[k-1];
            bit_chk = 1'b1;
            @(negedge clk);
            bit_chk = 1'b0;
            repeat (cpb - 1) @(negedge clk);
        end
    endtask

    task automatic run_uart(input int pin, input int cpb, input soc_bus_pkg::reg_sel_t data_reg,
                            input soc_bus_pkg::reg_sel_t stat_reg);
        soc_bus_pkg::byte_t b;
        soc_bus_pkg::word_t got;
        b = soc_bus_pkg::byte_t'($urandom);
        bus_write(reg_addr(data_reg), soc_bus_pkg::word_t'(b));
        fork
            sample_frame(pin, cpb, b);
            begin
                bus_read(reg_addr(stat_reg), 1'b1, 32'h1, got);
                bus_write(reg_addr(data_reg), soc_bus_pkg::word_t'(~b));  // Dropped while busy
            end
        join
        wait_idle(stat_reg, "UART");
        bus_read(reg_addr(stat_reg), 1'b1, 32'h0, got);
        check_pins(soc_bus_pkg::byte_t'(1 << pin), soc_bus_pkg::byte_t'(1 << pin));
    endtask

    task automatic run_spi(input logic end_txn);
        soc_bus_pkg::word_t got;
        bus_write(reg_addr(soc_bus_pkg::reg_spi_status), soc_bus_pkg::word_t'($urandom % 4));
        mst_byte = soc_bus_pkg::byte_t'($urandom);
        slv_byte = soc_bus_pkg::byte_t'($urandom);
        bus_write(reg_addr(soc_bus_pkg::reg_spi), {22'b0, 1'b1, end_txn, mst_byte});
        wait_idle(soc_bus_pkg::reg_spi_status, "SPI");
        bus_read(reg_addr(soc_bus_pkg::reg_spi), 1'b1, soc_bus_pkg::word_t'(slv_byte), got);
        check_pins(8'h30, {3'b0, end_txn, 4'b0});   // cs follows end_txn and sck is low
    endtask

    initial begin
        soc_bus_pkg::byte_t g;
        soc_bus_pkg::word_t got;
        void'($urandom(86));
        rd_chk    = 1'b0;
        pin_chk   = 1'b0;
        bit_chk   = 1'b0;
        spi_chk   = 1'b0;
        bit_exp   = 1'b0;
        rd_exp    = '0;
        pin_mask  = '0;
        pin_exp   = '0;
        bit_pos   = 0;
        rst_reg_n = 1'b0;
        bus_req   = '0;
        ui_drive  = '0;
        slv_byte  = '0;
        mst_byte  = '0;
        repeat (5) @(negedge clk);
        rst_reg_n = 1'b1;

        check_pins(8'hF1, 8'h11);   // Idle txd and cs high with sck low
        g = soc_bus_pkg::byte_t'($urandom);
        bus_write(reg_addr(soc_bus_pkg::reg_gpio_out_sel), 32'hFF);
        bus_write(reg_addr(soc_bus_pkg::reg_gpio_out), soc_bus_pkg::word_t'(g));
        check_pins(8'hFF, g);
        bus_read(reg_addr(soc_bus_pkg::reg_gpio_out), 1'b1, soc_bus_pkg::word_t'(g), got);
        ui_drive = soc_bus_pkg::byte_t'($urandom);
        slv_byte = soc_bus_pkg::byte_t'($urandom);
        @(negedge clk);
        bus_read(reg_addr(soc_bus_pkg::reg_gpio_in), 1'b1, soc_bus_pkg::word_t'(ui_in), got);

        // Outside the window and unused index
        bus_read(28'h0000000, 1'b1, soc_bus_pkg::unmapped_data, got);
        bus_read(reg_addr(4'h2), 1'b1, soc_bus_pkg::unmapped_data, got);
        bus_read(reg_addr(soc_bus_pkg::reg_gpio_out) | 28'h40, 1'b1, 32'hFFFF_FFFF, got);
        bus_write(28'h0000000, soc_bus_pkg::word_t'(~g));
        bus_write(28'h000000C, 32'h0);
        bus_write(reg_addr(4'h2), 32'h0);
        bus_read(reg_addr(soc_bus_pkg::reg_gpio_out), 1'b1, soc_bus_pkg::word_t'(g), got);
        bus_read(reg_addr(soc_bus_pkg::reg_gpio_out_sel), 1'b1, 32'hFF, got);
        bus_write(reg_addr(soc_bus_pkg::reg_gpio_out_sel), 32'h0);

        run_uart(0, periph_pkg::uart_clks_per_bit, soc_bus_pkg::reg_uart,
                 soc_bus_pkg::reg_uart_status);
        run_uart(1, periph_pkg::debug_uart_clks_per_bit, soc_bus_pkg::reg_debug_uart,
                 soc_bus_pkg::reg_debug_uart_status);
        spi_chk = 1'b1;
        run_spi(1'b0);
        run_spi(1'b1);
        spi_chk = 1'b0;

        $display("all tests passed");
        $finish;
    end

endmodule

// File: hw/periph_top.sv
// Top level of the memory-mapped peripheral block.
// The core drives bus_req; loads return rdata in the same cycle.
module periph_top (
    input  logic                  clk,
    input  logic                  rst_reg_n,
    input  soc_bus_pkg::bus_req_t bus_req,
    output soc_bus_pkg::word_t    rdata,
    input  soc_bus_pkg::byte_t    ui_in,
    output soc_bus_pkg::byte_t    uo_out
);

    periph_pkg::periph_access_t access;
    periph_pkg::periph_pins_t   pins;
    periph_pkg::periph_status_t status;
    soc_bus_pkg::byte_t         gpio_out;
    soc_bus_pkg::byte_t         gpio_out_sel;

    periph_decode decode_i (
        .bus_req (bus_req),
        .access  (access)
    );

    periph_execute execute_i (
        .clk          (clk),
        .rst_reg_n    (rst_reg_n),
        .access       (access),
        .ui_in        (ui_in),
        .pins         (pins),
        .status       (status),
        .gpio_out     (gpio_out),
        .gpio_out_sel (gpio_out_sel)
    );

    periph_result result_i (
        .access_sel   (access.sel),
        .ui_in        (ui_in),
        .pins         (pins),
        .status       (status),
        .gpio_out     (gpio_out),
        .gpio_out_sel (gpio_out_sel),
        .uo_out       (uo_out),
        .rdata        (rdata)
    );

endmodule

// File: hw/periph_result.sv
// Output-pin mux and read-data mux for the peripheral block.
// Both paths are combinational so a load completes in its strobe cycle.
module periph_result (
    input  soc_bus_pkg::reg_sel_t      access_sel,
    input  soc_bus_pkg::byte_t         ui_in,
    input  periph_pkg::periph_pins_t   pins,
    input  periph_pkg::periph_status_t status,
    input  soc_bus_pkg::byte_t         gpio_out,
    input  soc_bus_pkg::byte_t         gpio_out_sel,
    output soc_bus_pkg::byte_t         uo_out,
    output soc_bus_pkg::word_t         rdata
);

    soc_bus_pkg::byte_t pin_func;   // Peripheral function of each pin

    assign pin_func = {
        2'b00,
        pins.spi_sck,
        pins.spi_cs,
        pins.spi_mosi,
        pins.spi_dc,
        pins.debug_uart_txd,
        pins.uart_txd
    };

    // Per-bit choice between GPIO and peripheral
    assign uo_out = (gpio_out_sel & gpio_out) | (~gpio_out_sel & pin_func);

    always_comb begin
        case (access_sel)
            soc_bus_pkg::reg_gpio_out:
                rdata = soc_bus_pkg::word_t'(uo_out);   // Pin state, not the register
            soc_bus_pkg::reg_gpio_in:
                rdata = soc_bus_pkg::word_t'(ui_in);
            soc_bus_pkg::reg_gpio_out_sel:
                rdata = soc_bus_pkg::word_t'(gpio_out_sel);
            soc_bus_pkg::reg_uart_status:
                rdata = soc_bus_pkg::word_t'(status.uart_busy);
            soc_bus_pkg::reg_debug_uart_status:
                rdata = soc_bus_pkg::word_t'(status.debug_uart_busy);
            soc_bus_pkg::reg_spi:
                rdata = soc_bus_pkg::word_t'(status.spi_rdata);
            soc_bus_pkg::reg_spi_status:
                rdata = soc_bus_pkg::word_t'(status.spi_busy);
            default:
                rdata = soc_bus_pkg::unmapped_data;
        endcase
    end

endmodule

// File: hw/periph_execute.sv
// Peripheral state: GPIO registers, both UART transmitters and the SPI master.
// Write strobes from the decoded access start the engines and update registers.
module periph_execute (
    input  logic                       clk,
    input  logic                       rst_reg_n,
    input  periph_pkg::periph_access_t access,
    input  soc_bus_pkg::byte_t         ui_in,
    output periph_pkg::periph_pins_t   pins,
    output periph_pkg::periph_status_t status,
    output soc_bus_pkg::byte_t         gpio_out,
    output soc_bus_pkg::byte_t         gpio_out_sel
);

    soc_bus_pkg::byte_t   wbyte;
    periph_pkg::spi_div_t spi_div;
    logic                 uart_start;
    logic                 debug_uart_start;
    logic                 spi_start;
    logic                 spi_config;
    logic                 uart_txd;
    logic                 uart_busy;
    logic                 debug_uart_txd;
    logic                 debug_uart_busy;
    logic                 spi_cs;
    logic                 spi_sck;
    logic                 spi_mosi;
    logic                 spi_dc;
    logic                 spi_busy;
    soc_bus_pkg::byte_t   spi_rdata;

    assign wbyte   = access.wdata[7:0];
    assign spi_div = access.wdata[periph_pkg::spi_div_msb:periph_pkg::spi_div_lsb];

    assign uart_start       = access.write && (access.sel == soc_bus_pkg::reg_uart);
    assign debug_uart_start = access.write && (access.sel == soc_bus_pkg::reg_debug_uart);
    assign spi_start        = access.write && (access.sel == soc_bus_pkg::reg_spi);
    assign spi_config       = access.write && (access.sel == soc_bus_pkg::reg_spi_status);

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out     <= '0;
            gpio_out_sel <= '0;   // All pins start on their peripheral function
        end else if (access.write) begin
            if (access.sel == soc_bus_pkg::reg_gpio_out)     gpio_out     <= wbyte;
            if (access.sel == soc_bus_pkg::reg_gpio_out_sel) gpio_out_sel <= wbyte;
        end
    end

    uart_tx #(.clks_per_bit(periph_pkg::uart_clks_per_bit)) uart_i (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .start     (uart_start),
        .data      (wbyte),
        .txd       (uart_txd),
        .busy      (uart_busy)
    );

    uart_tx #(.clks_per_bit(periph_pkg::debug_uart_clks_per_bit)) debug_uart_i (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .start     (debug_uart_start),
        .data      (wbyte),
        .txd       (debug_uart_txd),
        .busy      (debug_uart_busy)
    );

    spi_ctrl spi_i (
        .clk        (clk),
        .rst_reg_n  (rst_reg_n),
        .start      (spi_start),
        .set_config (spi_config),
        .dc_in      (access.wdata[periph_pkg::spi_dc_bit]),
        .end_txn    (access.wdata[periph_pkg::spi_end_txn_bit]),
        .data_in    (wbyte),
        .divider_in (spi_div),
        .miso       (ui_in[periph_pkg::spi_miso_bit]),
        .cs         (spi_cs),
        .sck        (spi_sck),
        .mosi       (spi_mosi),
        .dc         (spi_dc),
        .busy       (spi_busy),
        .data_out   (spi_rdata)
    );

    always_comb begin
        pins.uart_txd       = uart_txd;
        pins.debug_uart_txd = debug_uart_txd;
        pins.spi_cs         = spi_cs;
        pins.spi_sck        = spi_sck;
        pins.spi_mosi       = spi_mosi;
        pins.spi_dc         = spi_dc;
    end

    always_comb begin
        status.uart_busy       = uart_busy;
        status.debug_uart_busy = debug_uart_busy;
        status.spi_busy        = spi_busy;
        status.spi_rdata       = spi_rdata;
    end

endmodule

// File: hw/periph_decode.sv
// Address decoder for the peripheral window.
// Turns a raw bus request into a register index plus strobes.
module periph_decode (
    input  soc_bus_pkg::bus_req_t      bus_req,
    output periph_pkg::periph_access_t access
);

    logic                  in_window;
    soc_bus_pkg::reg_sel_t index;

    // Bits outside 5:2 must hit the base exactly
    assign in_window = (bus_req.addr & ~soc_bus_pkg::reg_sel_mask) == soc_bus_pkg::periph_base;
    assign index     = bus_req.addr[soc_bus_pkg::reg_sel_msb:soc_bus_pkg::reg_sel_lsb];

    always_comb begin
        access.sel   = in_window ? index : soc_bus_pkg::reg_none;
        access.write = bus_req.write;
        access.read  = bus_req.read;
        access.wdata = bus_req.wdata;
    end

    // Core never loads and stores in the same cycle
    always_comb begin
        assert (!(bus_req.read && bus_req.write))
            else $error("periph_decode: read and write strobes both high");
    end

endmodule

// File: hw/spi_ctrl.sv
// Mode-0 byte SPI master with chip select, data/command line and a clock divider.
// cs stays low between bytes until a byte is sent with end_txn set.
module spi_ctrl (
    input  logic                 clk,
    input  logic                 rst_reg_n,
    input  logic                 start,
    input  logic                 set_config,
    input  logic                 dc_in,
    input  logic                 end_txn,
    input  soc_bus_pkg::byte_t   data_in,
    input  periph_pkg::spi_div_t divider_in,
    input  logic                 miso,
    output logic                 cs,
    output logic                 sck,
    output logic                 mosi,
    output logic                 dc,
    output logic                 busy,
    output soc_bus_pkg::byte_t   data_out
);

    periph_pkg::spi_state_e state;
    periph_pkg::spi_div_t   divider;
    periph_pkg::spi_div_t   div_cnt;    // Cycles within the current sck half
    logic [2:0]             bit_cnt;
    logic                   end_txn_q;
    logic                   miso_q;
    logic                   go;
    logic                   half_done;
    soc_bus_pkg::byte_t     shift;

    assign busy      = (state == periph_pkg::spi_shift);
    assign go        = start && !busy;
    assign half_done = busy && (div_cnt == divider);
    assign mosi      = shift[7];    // MSB first
    assign data_out  = shift;       // Full received byte once busy drops

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            state     <= periph_pkg::spi_idle;
            divider   <= '0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            end_txn_q <= 1'b0;
            cs        <= 1'b1;
            sck       <= 1'b0;
            dc        <= 1'b0;
        end else begin
            if (set_config && !busy) divider <= divider_in;

            if (go) begin
                state     <= periph_pkg::spi_shift;
                cs        <= 1'b0;
                dc        <= dc_in;     // Held for the whole byte
                end_txn_q <= end_txn;
                div_cnt   <= '0;
                bit_cnt   <= '0;
            end else if (busy) begin
                div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                if (half_done) begin
                    sck <= !sck;
                    // Falling edge closes a bit
                    if (sck) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= end_txn_q ? periph_pkg::spi_idle : periph_pkg::spi_hold;
                            cs    <= end_txn_q;
                        end
                    end
                end
            end
        end
    end

    // Sample on rising sck, shift on falling so MOSI moves only while sck is low
    always_ff @(posedge clk) begin
        if (go)                    shift <= data_in;
        else if (half_done && sck) shift <= {shift[6:0], miso_q};

        if (half_done && !sck) miso_q <= miso;
    end

    assert property (@(posedge clk) disable iff (!rst_reg_n) cs |-> !sck)
        else $error("spi_ctrl: sck active with cs deasserted");

endmodule

// File: hw/uart_tx.sv
// 8N1 byte transmitter, LSB first, with a fixed number of clocks per bit.
// Pulse start for one cycle with data valid; writes while busy are dropped.
module uart_tx #(
    parameter int clks_per_bit = periph_pkg::uart_clks_per_bit
) (
    input  logic               clk,
    input  logic               rst_reg_n,
    input  logic               start,
    input  soc_bus_pkg::byte_t data,
    output logic               txd,
    output logic               busy
);

    localparam int                 cnt_w    = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0]   cnt_last = cnt_w'(clks_per_bit - 1);

    periph_pkg::uart_state_e state;
    logic [cnt_w-1:0]        cnt;       // Cycles within the current bit
    logic [2:0]              bit_idx;
    logic                    bit_end;
    soc_bus_pkg::byte_t      shift;

    assign bit_end = (cnt == cnt_last);
    assign busy    = (state != periph_pkg::uart_idle);

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            state   <= periph_pkg::uart_idle;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;    // Line idles high
        end else begin
            if (!busy || bit_end) cnt <= '0;
            else                  cnt <= cnt + 1'b1;

            case (state)
                periph_pkg::uart_idle: begin
                    if (start) begin
                        state <= periph_pkg::uart_start;
                        txd   <= 1'b0;
                    end
                end
                periph_pkg::uart_start: begin
                    if (bit_end) begin
                        state <= periph_pkg::uart_data;
                        txd   <= shift[0];
                    end
                end
                periph_pkg::uart_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;   // Wraps to 0 after the last bit
                        if (bit_idx == 3'd7) begin
                            state <= periph_pkg::uart_stop;
                            txd   <= 1'b1;
                        end else begin
                            txd <= shift[1];  // Next bit before the shift lands
                        end
                    end
                end
                periph_pkg::uart_stop: begin
                    if (bit_end) state <= periph_pkg::uart_idle;
                end
                default: state <= periph_pkg::uart_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == periph_pkg::uart_idle && start) shift <= data;
        else if (state == periph_pkg::uart_data && bit_end) shift <= shift >> 1;
    end

    // Line must be high between frames
    assert property (@(posedge clk) disable iff (!rst_reg_n)
        (state == periph_pkg::uart_idle) |-> txd)
        else $error("uart_tx: txd low while idle");

endmodule

// File: hw/periph_pkg.sv
// Peripheral register layouts, bit-rate constants and state encodings.
// Used by the peripheral modules and the testbench checkers.
package periph_pkg;

    // Decoded access as seen by the peripherals
    typedef struct packed {
        soc_bus_pkg::reg_sel_t sel;
        logic                  write;
        logic                  read;
        soc_bus_pkg::word_t    wdata;
    } periph_access_t;

    typedef struct packed {
        logic               uart_busy;
        logic               debug_uart_busy;
        logic               spi_busy;
        soc_bus_pkg::byte_t spi_rdata;
    } periph_status_t;

    typedef struct packed {
        logic uart_txd;
        logic debug_uart_txd;
        logic spi_cs;
        logic spi_sck;
        logic spi_mosi;
        logic spi_dc;
    } periph_pins_t;

    // Clocks per UART bit
    localparam int uart_clks_per_bit       = 32;
    localparam int debug_uart_clks_per_bit = 4;   // Fast debug port

    // SPI write-data fields
    localparam int spi_dc_bit      = 9;
    localparam int spi_end_txn_bit = 8;
    localparam int spi_div_msb     = 1;
    localparam int spi_div_lsb     = 0;
    localparam int spi_miso_bit    = 2;   // Position on ui_in

    typedef logic [1:0] spi_div_t;

    typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_e;
    typedef enum logic [1:0] {spi_idle, spi_shift, spi_hold} spi_state_e;

endpackage

// File: hw/soc_bus_pkg.sv
// Data-bus types, widths and the peripheral address map.
// Shared by the bus side of the design and by the testbench that drives the bus.
package soc_bus_pkg;

    localparam int addr_w = 28;
    localparam int word_w = 32;
    localparam int byte_w = 8;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [byte_w-1:0] byte_t;
    typedef logic [3:0]        reg_sel_t;

    // Single-cycle request from the core
    typedef struct packed {
        addr_t addr;
        logic  write;
        logic  read;
        word_t wdata;
    } bus_req_t;

    // Register index field inside the address
    localparam int    reg_sel_lsb  = 2;
    localparam int    reg_sel_msb  = 5;
    localparam addr_t reg_sel_mask = 28'h000003C;

    // Every bit outside the index field must match this
    localparam addr_t periph_base = 28'h8000000;

    localparam word_t unmapped_data = 32'hFFFF_FFFF;

    // Register indices, address bits 5:2
    localparam reg_sel_t reg_gpio_out          = 4'h0;
    localparam reg_sel_t reg_gpio_in           = 4'h1;
    localparam reg_sel_t reg_gpio_out_sel      = 4'h3;
    localparam reg_sel_t reg_uart              = 4'h4;
    localparam reg_sel_t reg_uart_status       = 4'h5;
    localparam reg_sel_t reg_debug_uart        = 4'h6;
    localparam reg_sel_t reg_debug_uart_status = 4'h7;
    localparam reg_sel_t reg_spi               = 4'h8;
    localparam reg_sel_t reg_spi_status        = 4'h9;
    localparam reg_sel_t reg_none              = 4'hF;  // Outside the window

endpackage
